//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module boot_tb -f flist.f -o boot_sim
	./obj_dir/boot_sim | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
source/boot_pkg.sv
source/uart_receiver.sv
source/rom_loader.sv
source/program_rom.sv
source/boot_top.sv
testbench/boot_tb.sv

//--- source/boot_pkg.sv
`default_nettype none

package boot_pkg;

    // ****************************************
    // Program ROM geometry
    // ****************************************

    localparam int ROM_ADDR_W = 14; // 16K words of program space.
    localparam int ROM_DATA_W = 32; // One instruction per word.

    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
    typedef logic [ROM_DATA_W-1:0] rom_word_t;

    // ****************************************
    // Serial loader protocol
    // ****************************************

    typedef logic [7:0] byte_t;

    // A frame is the start byte, a 16-bit word count (low byte first),
    // the data words (low byte first) and an XOR checksum byte.
    localparam byte_t LOAD_START = 8'hA5;

endpackage

`default_nettype wire

//--- source/boot_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_top #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uart_rx,
    input  boot_pkg::rom_addr_t rom_rd_addr,
    output boot_pkg::rom_word_t rom_rd_data,
    output logic                system_soft_reset,
    output logic                load_ok,
    output logic [15:0]         load_count
);

    // ****************************************
    // Serial receive path
    // ****************************************

    boot_pkg::byte_t uart_receiver_data;
    logic uart_receiver_valid;
    uart_receiver #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_receiver0 (
        .clk(clk),
        .rst_n(rst_n),
        .rx(uart_rx),
        .rx_data(uart_receiver_data),
        .rx_valid(uart_receiver_valid)
    );

    logic program_rom_wr_en;
    boot_pkg::rom_addr_t program_rom_wr_addr;
    boot_pkg::rom_word_t program_rom_wr_data;
    rom_loader rom_loader0 (
        .clk(clk),
        .rst_n(rst_n),
        .rx_data(uart_receiver_data),
        .rx_valid(uart_receiver_valid),
        .rom_wr_en(program_rom_wr_en),
        .rom_wr_addr(program_rom_wr_addr),
        .rom_wr_data(program_rom_wr_data),
        .system_soft_reset(system_soft_reset),
        .load_ok(load_ok),
        .load_count(load_count)
    );

    // ****************************************
    // Program memory
    // ****************************************

    program_rom program_rom0 (
        .clk(clk),
        .wr_en(program_rom_wr_en),
        .wr_addr(program_rom_wr_addr),
        .wr_data(program_rom_wr_data),
        .rd_addr(rom_rd_addr), // Processor fetch port.
        .rd_data(rom_rd_data)
    );

endmodule

`default_nettype wire

//--- source/program_rom.sv
`timescale 1ns/1ps
`default_nettype none

module program_rom (
    input  logic                clk,
    input  logic                wr_en,
    input  boot_pkg::rom_addr_t wr_addr,
    input  boot_pkg::rom_word_t wr_data,
    input  boot_pkg::rom_addr_t rd_addr,
    output boot_pkg::rom_word_t rd_data
);

    localparam int DEPTH = 2 ** boot_pkg::ROM_ADDR_W;

    boot_pkg::rom_word_t mem [DEPTH];

    // ****************************************
    // Block RAM ports
    // ****************************************

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // Same-address write returns the old word.
    end

endmodule

`default_nettype wire

//--- source/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  boot_pkg::byte_t     rx_data,
    input  logic                rx_valid,
    output logic                rom_wr_en,
    output boot_pkg::rom_addr_t rom_wr_addr,
    output boot_pkg::rom_word_t rom_wr_data,
    output logic                system_soft_reset,
    output logic                load_ok,
    output logic [15:0]         load_count
);

    localparam int BYTES_PER_WORD = boot_pkg::ROM_DATA_W / 8;
    localparam int IDX_W = $clog2(BYTES_PER_WORD);
    localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(BYTES_PER_WORD - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COUNT_LO,
        ST_COUNT_HI,
        ST_DATA,
        ST_CHECKSUM
    } state_t;

    state_t state;
    logic [15:0] words_left;
    logic [IDX_W-1:0] byte_idx;
    boot_pkg::byte_t count_lo;
    boot_pkg::byte_t checksum;
    boot_pkg::rom_word_t word_sr;
    logic [15:0] frame_count;
    logic last_byte;

    assign frame_count = {rx_data, count_lo};
    assign last_byte = (byte_idx == LAST_BYTE);

    // ****************************************
    // Frame parser
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            words_left <= '0;
            byte_idx <= '0;
            rom_wr_en <= 1'b0;
            rom_wr_addr <= '0;
            system_soft_reset <= 1'b0;
            load_ok <= 1'b0;
            load_count <= '0;
        end else begin
            rom_wr_en <= 1'b0;
            if (rom_wr_en) begin
                rom_wr_addr <= rom_wr_addr + 1'b1; // Next word goes one address up.
            end
            if (rx_valid) begin
                case (state)
                    ST_IDLE: begin
                        if (rx_data == boot_pkg::LOAD_START) begin
                            state <= ST_COUNT_LO;
                            system_soft_reset <= 1'b1; // Hold the CPU while loading.
                            load_ok <= 1'b0;
                        end
                    end
                    ST_COUNT_LO: begin
                        state <= ST_COUNT_HI;
                    end
                    ST_COUNT_HI: begin
                        load_count <= frame_count;
                        words_left <= frame_count;
                        byte_idx <= '0;
                        rom_wr_addr <= '0;
                        state <= (frame_count == 16'd0) ? ST_CHECKSUM : ST_DATA;
                    end
                    ST_DATA: begin
                        byte_idx <= byte_idx + 1'b1;
                        if (last_byte) begin
                            rom_wr_en <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 16'd1) begin
                                state <= ST_CHECKSUM;
                            end
                        end
                    end
                    ST_CHECKSUM: begin
                        load_ok <= (rx_data == checksum);
                        system_soft_reset <= 1'b0;
                        state <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Byte datapath for the count, the data word and the checksum.
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                ST_IDLE: checksum <= '0;
                ST_COUNT_LO: count_lo <= rx_data;
                ST_DATA: begin
                    word_sr <= {rx_data, word_sr[boot_pkg::ROM_DATA_W-1:8]};
                    checksum <= checksum ^ rx_data;
                end
                default: ;
            endcase
        end
    end

    assign rom_wr_data = word_sr; // Complete in the cycle after the last byte.

    a_wr_in_soft_reset : assert property (
        @(posedge clk) disable iff (!rst_n) rom_wr_en |-> system_soft_reset
    );

    a_wr_single : assert property (
        @(posedge clk) disable iff (!rst_n) rom_wr_en |=> !rom_wr_en
    );

endmodule

`default_nettype wire

//--- source/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rx,
    output boot_pkg::byte_t rx_data,
    output logic           rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    logic [1:0] rx_sync; // The line is asynchronous to clk.
    logic rx_s;
    state_t state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_cnt;
    boot_pkg::byte_t shift_reg;
    logic bit_tick;

    assign rx_s = rx_sync[1];
    assign bit_tick = (clk_cnt == BIT_END);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11; // Idle line level.
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    // ****************************************
    // Bit timing FSM
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!rx_s) begin
                        state <= ST_START;
                        clk_cnt <= CNT_W'(1); // This cycle already counts as one.
                    end
                end
                ST_START: begin
                    if (clk_cnt == HALF_END) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_s ? ST_IDLE : ST_DATA; // Reject glitches.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        state <= ST_IDLE; // Rest of the stop bit is high anyway.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_tick) begin
            shift_reg <= {rx_s, shift_reg[7:1]}; // LSB arrives first.
        end
    end

    assign rx_data = shift_reg;
    assign rx_valid = (state == ST_STOP) && bit_tick && rx_s; // Low stop bit drops the byte.

    a_rx_valid_single : assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    );

endmodule

`default_nettype wire

//--- testbench/boot_tb.sv
`timescale 1ns/1ps
`default_nettype none

module boot_tb;

    localparam int CLKS_PER_BIT = 16;
    localparam int TIMEOUT_CYCLES = 200000; // About 600 bytes at 160 cycles each, plus margin.
    localparam int MODEL_WORDS = 16; // Largest random frame.

    logic clk;
    logic rst_n;
    logic uart_rx;
    boot_pkg::rom_addr_t rom_rd_addr;
    boot_pkg::rom_word_t rom_rd_data;
    logic system_soft_reset;
    logic load_ok;
    logic [15:0] load_count;

    boot_pkg::rom_word_t model [MODEL_WORDS]; // Expected ROM contents.
    int model_depth = 0; // Words of the model that hold loaded data.
    logic [31:0] lfsr = 32'h1423_1780;
    int cycle_count = 0;
    int num_checks = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string test_name = "none";

    boot_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) boot_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .uart_rx(uart_rx),
        .rom_rd_addr(rom_rd_addr),
        .rom_rd_data(rom_rd_data),
        .system_soft_reset(system_soft_reset),
        .load_ok(load_ok),
        .load_count(load_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish.", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // ****************************************
    // Random numbers
    // ****************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003; // Taps of x^32 + x^22 + x^2 + x + 1.
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ****************************************
    // UART serializer
    // ****************************************

    task automatic drive_bit(input logic v);
        @(posedge clk);
        #1;
        uart_rx = v;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic idle_bits(input int n);
        for (int i = 0; i < n; i++) begin
            drive_bit(1'b1);
        end
    endtask

    // The loader has taken the byte by the time this returns.
    task automatic send_byte(input boot_pkg::byte_t b, input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop);
    endtask

    task automatic random_gap();
        logic [31:0] r;
        take_bits(2, r);
        idle_bits(int'(r[1:0])); // Zero to three idle bit times.
    endtask

    // Data bytes are random and the model is updated word by word.
    task automatic send_frame(input logic [15:0] count, input logic bad_sum);
        logic [31:0] r;
        boot_pkg::byte_t b;
        boot_pkg::byte_t sum;
        boot_pkg::rom_word_t w;
        sum = '0;
        w = '0;
        random_gap();
        send_byte(boot_pkg::LOAD_START, 1'b1);
        send_byte(count[7:0], 1'b1);
        send_byte(count[15:8], 1'b1);
        for (int i = 0; i < int'(count); i++) begin
            for (int k = 0; k < 4; k++) begin
                take_bits(8, r);
                b = r[7:0];
                w[8*k +: 8] = b; // Low byte first.
                sum = sum ^ b;
                random_gap();
                send_byte(b, 1'b1);
                @(negedge clk);
                check_flag("soft reset during data", 1'b1, system_soft_reset);
            end
            model[i] = w;
        end
        if (bad_sum) begin
            sum = ~sum;
        end
        send_byte(sum, 1'b1);
        if (int'(count) > model_depth) begin
            model_depth = int'(count);
        end
    endtask

    // ****************************************
    // Checks
    // ****************************************

    task automatic check_word(input string what, input boot_pkg::rom_word_t exp,
                              input boot_pkg::rom_word_t act);
        num_checks++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        num_checks++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s, %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        num_checks++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic read_word(input int addr, output boot_pkg::rom_word_t w);
        @(posedge clk);
        #1;
        rom_rd_addr = boot_pkg::rom_addr_t'(addr);
        @(posedge clk); // One cycle of read latency.
        @(negedge clk);
        w = rom_rd_data;
    endtask

    task automatic verify_rom(input int n);
        boot_pkg::rom_word_t w;
        for (int i = 0; i < n; i++) begin
            read_word(i, w);
            check_word($sformatf("rom word %0d", i), model[i], w);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("%s: pass", test_name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // ****************************************
    // Test sequence
    // ****************************************

    initial begin
        logic [31:0] r;
        boot_pkg::byte_t b;
        int n;
        uart_rx = 1'b1;
        rom_rd_addr = '0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset_state");
        @(negedge clk);
        check_flag("soft reset", 1'b0, system_soft_reset);
        check_flag("load_ok", 1'b0, load_ok);
        check_count("load_count", 16'd0, load_count);
        finish_test();

        start_test("load_readback");
        take_bits(4, r);
        n = int'(r[3:0]) + 1;
        send_frame(16'(n), 1'b0);
        idle_bits(2);
        verify_rom(n);
        finish_test();

        start_test("load_status");
        @(negedge clk);
        check_flag("load_ok after good frame", 1'b1, load_ok);
        check_count("load_count after good frame", 16'(n), load_count);
        take_bits(4, r);
        n = int'(r[3:0]) + 1;
        send_frame(16'(n), 1'b1);
        idle_bits(2);
        @(negedge clk);
        check_flag("load_ok after bad checksum", 1'b0, load_ok);
        check_count("load_count after bad checksum", 16'(n), load_count);
        verify_rom(model_depth); // Words of a bad frame are still written.
        finish_test();

        start_test("soft_reset");
        take_bits(4, r);
        n = int'(r[3:0]) + 1;
        send_frame(16'(n), 1'b0);
        idle_bits(3);
        @(negedge clk);
        check_flag("soft reset after checksum", 1'b0, system_soft_reset);
        check_flag("load_ok", 1'b1, load_ok);
        verify_rom(model_depth);
        finish_test();

        start_test("idle_bytes");
        for (int i = 0; i < 8; i++) begin
            take_bits(8, r);
            b = r[7:0];
            if (b == boot_pkg::LOAD_START) begin
                b = b ^ 8'h01;
            end
            send_byte(b, 1'b1);
            @(negedge clk);
            check_flag("soft reset on idle byte", 1'b0, system_soft_reset);
        end
        verify_rom(model_depth);
        finish_test();

        start_test("framing_error");
        send_byte(boot_pkg::LOAD_START, 1'b0); // Low stop bit.
        idle_bits(2);
        @(negedge clk);
        check_flag("soft reset after bad stop bit", 1'b0, system_soft_reset);
        take_bits(4, r);
        n = int'(r[3:0]) + 1;
        send_frame(16'(n), 1'b0);
        idle_bits(2);
        @(negedge clk);
        check_flag("load_ok", 1'b1, load_ok);
        check_count("load_count", 16'(n), load_count);
        verify_rom(model_depth);
        finish_test();

        start_test("zero_length");
        send_frame(16'd0, 1'b0);
        idle_bits(2);
        @(negedge clk);
        check_flag("load_ok", 1'b1, load_ok);
        check_count("load_count", 16'd0, load_count);
        check_flag("soft reset", 1'b0, system_soft_reset);
        verify_rom(model_depth);
        finish_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, num_checks, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
